// ==== sim.f ====
hw/vrc6_pkg.sv
hw/vrc6_bank_regs.sv
hw/vrc6_addr_map.sv
hw/vrc_irq.sv
hw/vrc6_pulse.sv
hw/vrc6_saw.sv
hw/vrc6_top.sv
bench/tb_clock.sv
bench/vrc6_tb.sv

// ==== bench/vrc6_tb.sv ====
// VRC6 mapper testbench

`timescale 1ns/1ps

module vrc6_tb;

	localparam int K_PRG       = 0;
	localparam int K_RAM       = 1;
	localparam int K_CHR       = 2;
	localparam int K_A10       = 3;
	localparam int K_CIRAM     = 4;
	localparam int K_AUDIO     = 5;
	localparam int K_IRQ_RISE  = 6;   // Probe field is a strobe count from here on
	localparam int K_IRQ_HIGHS = 7;
	localparam int K_AUD_HIGHS = 8;
	localparam int K_AUD_MAX   = 9;

	logic clk, rst_n, ce, cpu_we, prg_ram_sel, ciram_ce, ciram_a10, irq;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_din;
	logic [13:0] ppu_addr;
	logic [18:0] prg_rom_addr;
	logic [17:0] chr_rom_addr;
	logic [5:0]  audio;
	logic [31:0] lfsr_state;
	int          cycles = 0;
	int          cycle_limit;

	string       row_name[$];
	int          row_kind[$];
	logic [15:0] row_waddr[$];   // Zero means no write
	logic [7:0]  row_wdata[$];
	logic [15:0] row_probe[$];
	int          row_expected[$];

	tb_clock u_clock (.clk, .rst_n);

	vrc6_top #(.SWAP_A01(1'b0)) u_vrc6_top (
		.clk, .rst_n, .ce, .cpu_addr, .cpu_we, .cpu_din, .ppu_addr,
		.prg_rom_addr, .prg_ram_sel, .chr_rom_addr, .ciram_ce, .ciram_a10, .irq, .audio
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// 8 KiB page by CPU window, fixed last page on top
	function automatic int prg_expect(input logic [15:0] a, input logic [4:0] p16,
			input logic [5:0] p8);
		logic [5:0] page;
		case (a[15:13])
			3'b100, 3'b101: page = {p16, a[13]};
			3'b110:         page = p8;
			default:        page = 6'h3F;
		endcase
		return {page, a[12:0]};
	endfunction

	function automatic int a10_expect(input int mode, input logic [13:0] a);
		case (mode)
			0:       return a[10];   // Vertical
			1:       return a[11];   // Horizontal
			2:       return 0;
			default: return 1;
		endcase
	endfunction

	task automatic add_row(input string name, input int kind, input logic [15:0] waddr,
			input logic [7:0] wdata, input logic [15:0] probe, input int expected);
		row_name.push_back(name);
		row_kind.push_back(kind);
		row_waddr.push_back(waddr);
		row_wdata.push_back(wdata);
		row_probe.push_back(probe);
		row_expected.push_back(expected);
	endtask

	task automatic build_table();
		logic [4:0]  p16;
		logic [5:0]  p8;
		logic [7:0]  chr [8];
		logic [9:0]  ofs;
		logic [15:0] nt;
		int          latch;
		add_row("reset_irq", K_IRQ_HIGHS, 16'h0, 8'h0, 16'd4, 0);
		add_row("reset_audio", K_AUDIO, 16'h0, 8'h0, 16'h0, 0);
		add_row("reset_prg", K_PRG, 16'h0, 8'h0, 16'h8000, prg_expect(16'h8000, 5'd0, 6'd0));
		add_row("reset_chr", K_CHR, 16'h0, 8'h0, 16'h0123, 32'h0123);
		for (int n = 0; n < 4; n++) begin
			nt = 16'h21A5 + 16'(n) * 16'h400;
			add_row($sformatf("reset_nt%0d", n), K_A10, 16'h0, 8'h0, nt, a10_expect(0, nt[13:0]));
		end
		add_row("ciram_ce_pattern", K_CIRAM, 16'h0, 8'h0, 16'h0123, 0);   // A13 low
		add_row("ciram_ce_nt", K_CIRAM, 16'h0, 8'h0, 16'h21A5, 1);
		p16 = 5'(random_bits(5));
		p8  = 6'(random_bits(6));
		add_row("prg16_8000", K_PRG, 16'h8000, {3'b000, p16}, 16'h8123,
			prg_expect(16'h8123, p16, 6'd0));
		add_row("prg8_c000", K_PRG, 16'hC000, {2'b00, p8}, 16'hC789, prg_expect(16'hC789, p16, p8));
		add_row("prg16_a000", K_PRG, 16'h0, 8'h0, 16'hA456, prg_expect(16'hA456, p16, p8));
		add_row("prg_fixed_e000", K_PRG, 16'h0, 8'h0, 16'hFABC, prg_expect(16'hFABC, p16, p8));
		add_row("prg_ram_6000", K_RAM, 16'h0, 8'h0, 16'h6000, 1);
		add_row("prg_ram_8000", K_RAM, 16'h0, 8'h0, 16'h8000, 0);
		for (int i = 0; i < 8; i++) begin
			chr[i] = 8'(random_bits(8));
			ofs    = 10'(random_bits(10));
			add_row($sformatf("chr_bank%0d", i), K_CHR,
				(i < 4) ? 16'hD000 + 16'(i) : 16'hE000 + 16'(i - 4),
				chr[i], {3'b000, 3'(i), ofs}, {chr[i], ofs});
		end
		for (int i = 7; i >= 0; i--) begin
			ofs = 10'(random_bits(10));
			add_row($sformatf("chr_recheck%0d", i), K_CHR, 16'h0, 8'h0,
				{3'b000, 3'(i), ofs}, {chr[i], ofs});
		end
		for (int m = 0; m < 4; m++) begin
			for (int n = 0; n < 4; n++) begin
				nt = 16'h21A5 + 16'(n) * 16'h400;
				add_row($sformatf("mirror%0d_nt%0d", m, n), K_A10, (n == 0) ? 16'hB003 : 16'h0,
					8'(m << 2), nt, a10_expect(m, nt[13:0]));
			end
		end
		latch = 'hF0;
		add_row("irq_latch", K_IRQ_HIGHS, 16'hF000, 8'(latch), 16'd4, 0);
		add_row("irq_cycle_mode", K_IRQ_RISE, 16'hF001, 8'h06, 16'd24, 256 - latch);   // M=1 E=1
		add_row("irq_ack", K_IRQ_HIGHS, 16'hF002, 8'h00, 16'd40, 0);
		add_row("pulse_freq_lo", K_AUDIO, 16'h9001, 8'h00, 16'h0, 0);
		add_row("pulse_mode1", K_AUDIO, 16'h9000, 8'h89, 16'h0, 0);   // Not enabled yet
		add_row("pulse_enable", K_AUDIO, 16'h9002, 8'h80, 16'h0, 9);
		add_row("pulse2_freq_lo", K_AUDIO, 16'hA001, 8'h00, 16'h0, 9);
		add_row("pulse2_mode1", K_AUDIO, 16'hA000, 8'h85, 16'h0, 9);
		add_row("pulse2_enable", K_AUDIO, 16'hA002, 8'h80, 16'h0, 9 + 5);   // Both channels summed
		add_row("pulse2_disable", K_AUDIO, 16'hA002, 8'h00, 16'h0, 9);
		add_row("pulse_duty3", K_AUD_HIGHS, 16'h9000, 8'h39, 16'd16, 3 + 1);
		add_row("pulse_disable", K_AUDIO, 16'h9002, 8'h00, 16'h0, 0);
		add_row("saw_rate", K_AUDIO, 16'hB000, 8'd8, 16'h0, 0);
		add_row("saw_freq_lo", K_AUDIO, 16'hB001, 8'h00, 16'h0, 0);
		add_row("saw_peak", K_AUD_MAX, 16'hB002, 8'h80, 16'd28, (8 * 6) >> 3);
	endtask

	// One CPU cycle of 4 clocks, ce high for the first
	task automatic bus_cycle(input logic [15:0] addr, input logic we, input logic [7:0] data,
			input logic [13:0] ppu);
		@(negedge clk);
		cpu_addr = addr;
		cpu_we   = we;
		cpu_din  = data;
		ppu_addr = ppu;
		ce       = 1'b1;
		@(negedge clk);
		ce     = 1'b0;
		cpu_we = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic run_row(input int r);
		logic [31:0] act;
		int          rise;
		int          irq_highs;
		int          aud_highs;
		int          peak;
		rise      = 0;
		irq_highs = 0;
		aud_highs = 0;
		peak      = 0;
		if (row_waddr[r] != 16'h0000) begin
			bus_cycle(row_waddr[r], 1'b1, row_wdata[r], 14'h0);
		end
		case (row_kind[r])
			K_PRG, K_RAM: begin
				bus_cycle(row_probe[r], 1'b0, 8'h00, 14'h0);
				act = (row_kind[r] == K_PRG) ? 32'(prg_rom_addr) : 32'(prg_ram_sel);
			end
			K_CHR, K_A10, K_CIRAM: begin
				bus_cycle(16'h0000, 1'b0, 8'h00, row_probe[r][13:0]);
				case (row_kind[r])
					K_CHR:   act = 32'(chr_rom_addr);
					K_A10:   act = 32'(ciram_a10);
					default: act = 32'(ciram_ce);
				endcase
			end
			K_AUDIO: begin
				bus_cycle(16'h0000, 1'b0, 8'h00, 14'h0);
				act = 32'(audio);
			end
			default: begin
				for (int n = 1; n <= int'(row_probe[r]); n++) begin
					bus_cycle(16'h0000, 1'b0, 8'h00, 14'h0);
					if (irq === 1'b1 && rise == 0) rise = n;
					if (irq !== 1'b0) irq_highs++;
					if (audio !== 6'd0) aud_highs++;
					if (audio > peak) peak = audio;
				end
				case (row_kind[r])
					K_IRQ_RISE:  act = rise;   // Strobe after which irq was first seen high
					K_IRQ_HIGHS: act = irq_highs;
					K_AUD_HIGHS: act = aud_highs;
					default:     act = peak;
				endcase
			end
		endcase
		check_value(row_name[r], row_expected[r], act);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	initial begin
		ce         = 1'b0;
		cpu_we     = 1'b0;
		cpu_addr   = '0;
		cpu_din    = '0;
		ppu_addr   = '0;
		lfsr_state = 32'd69474;
		build_table();
		cycle_limit = row_name.size() * 16 + 4000;
		@(posedge rst_n);
		for (int r = 0; r < row_name.size(); r++) begin
			run_row(r);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);   // Release between sampling edges
		rst_n = 1'b1;
	end

endmodule

// ==== hw/vrc6_top.sv ====
// Konami VRC6 mapper top level

`timescale 1ns/1ps

module vrc6_top #(
	parameter bit SWAP_A01 = 1'b0   // Mapper 26 wiring
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,
	input  vrc6_pkg::cpu_addr_t cpu_addr,
	input  logic                cpu_we,
	input  vrc6_pkg::byte_t     cpu_din,
	input  vrc6_pkg::ppu_addr_t ppu_addr,
	output logic [18:0]         prg_rom_addr,
	output logic                prg_ram_sel,
	output logic [17:0]         chr_rom_addr,
	output logic                ciram_ce,
	output logic                ciram_a10,
	output logic                irq,
	output vrc6_pkg::level_t    audio
);

	vrc6_pkg::cpu_addr_t reg_addr;
	logic [4:0]          prg16_bank;
	vrc6_pkg::prg_bank_t prg8_bank;
	vrc6_pkg::chr_bank_t chr_banks [8];
	vrc6_pkg::mirror_e   mirror;
	logic [3:0]          pulse1_level;
	logic [3:0]          pulse2_level;
	logic [4:0]          saw_level;

	// Register select lines, A0 and A1 exchanged on mapper 26
	assign reg_addr = SWAP_A01 ? {cpu_addr[15:2], cpu_addr[0], cpu_addr[1]} : cpu_addr;

	vrc6_bank_regs u_bank_regs (
		.clk, .rst_n, .ce, .cpu_we, .reg_addr, .cpu_din,
		.prg16_bank, .prg8_bank, .chr_banks, .mirror
	);

	vrc6_addr_map u_addr_map (
		.cpu_addr, .ppu_addr, .prg16_bank, .prg8_bank, .chr_banks, .mirror,
		.prg_rom_addr, .prg_ram_sel, .chr_rom_addr, .ciram_ce, .ciram_a10
	);

	vrc_irq u_irq (
		.clk, .rst_n, .ce, .cpu_we, .reg_addr, .cpu_din, .irq
	);

	vrc6_pulse #(.PAGE(vrc6_pkg::PG_PULSE1)) u_pulse1 (
		.clk, .rst_n, .ce, .cpu_we, .reg_addr, .cpu_din,
		.level (pulse1_level)
	);

	vrc6_pulse #(.PAGE(vrc6_pkg::PG_PULSE2)) u_pulse2 (
		.clk, .rst_n, .ce, .cpu_we, .reg_addr, .cpu_din,
		.level (pulse2_level)
	);

	vrc6_saw u_saw (
		.clk, .rst_n, .ce, .cpu_we, .reg_addr, .cpu_din,
		.level (saw_level)
	);

	// 15 + 15 + 31 fits in six bits
	assign audio = {2'b00, pulse1_level} + {2'b00, pulse2_level} + {1'b0, saw_level};

endmodule

// ==== hw/vrc6_saw.sv ====
// VRC6 sawtooth channel

`timescale 1ns/1ps

module vrc6_saw (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,
	input  logic                cpu_we,
	input  vrc6_pkg::cpu_addr_t reg_addr,
	input  vrc6_pkg::byte_t     cpu_din,
	output logic [4:0]          level
);

	logic        wr;
	logic [5:0]  rate;
	logic [11:0] freq;
	logic        en;
	logic [12:0] div;
	logic [2:0]  step;
	logic [7:0]  acc;

	assign wr = ce & cpu_we & (reg_addr[15:12] == vrc6_pkg::PG_SAW);

	always_ff @(posedge clk) begin
		if (wr) begin
			case (reg_addr[1:0])
				2'd0:    rate       <= cpu_din[5:0];
				2'd1:    freq[7:0]  <= cpu_din;
				2'd2:    freq[11:8] <= cpu_din[3:0];
				default: ;   // B003 is the mirroring register
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
			acc  <= '0;
		end else if (ce) begin
			if (wr && reg_addr[1:0] == 2'd2) begin
				en <= cpu_din[7];
			end
			if (en) begin
				if (div != 13'd0) begin
					div <= div - 13'd1;
				end else begin
					div <= {freq, 1'b1};   // Twice freq plus one
					if (step == 3'd6) begin
						step <= '0;
						acc  <= '0;
					end else begin
						step <= step + 3'd1;
						acc  <= acc + {2'b00, rate};
					end
				end
			end
		end
	end

	assign level = en ? acc[7:3] : 5'd0;

endmodule

// ==== hw/vrc6_pulse.sv ====
// VRC6 pulse channel

`timescale 1ns/1ps

module vrc6_pulse #(
	parameter vrc6_pkg::reg_page_e PAGE = vrc6_pkg::PG_PULSE1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,
	input  logic                cpu_we,
	input  vrc6_pkg::cpu_addr_t reg_addr,
	input  vrc6_pkg::byte_t     cpu_din,
	output logic [3:0]          level
);

	logic        wr;
	logic        mode;    // Constant volume, ignores duty
	logic [2:0]  duty;
	logic [3:0]  vol;
	logic [11:0] freq;
	logic        en;
	logic [11:0] div;
	logic [3:0]  step;

	assign wr = ce & cpu_we & (reg_addr[15:12] == PAGE);

	always_ff @(posedge clk) begin
		if (wr) begin
			case (reg_addr[1:0])
				2'd0:    {mode, duty, vol} <= cpu_din;
				2'd1:    freq[7:0]         <= cpu_din;
				2'd2:    freq[11:8]        <= cpu_din[3:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
		end else if (ce) begin
			if (wr && reg_addr[1:0] == 2'd2) begin
				en <= cpu_din[7];
			end
			if (en) begin
				if (div != 12'd0) begin
					div <= div - 12'd1;
				end else begin
					div  <= freq;
					step <= step + 4'd1;   // 16-step duty sequence
				end
			end
		end
	end

	assign level = (en && (mode || step <= {1'b0, duty})) ? vol : 4'd0;

endmodule

// ==== hw/vrc_irq.sv ====
// VRC IRQ counter with scanline prescaler

`timescale 1ns/1ps

module vrc_irq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,
	input  logic                cpu_we,
	input  vrc6_pkg::cpu_addr_t reg_addr,
	input  vrc6_pkg::byte_t     cpu_din,
	output logic                irq
);

	logic            page_wr;
	logic            latch_wr;
	logic            ctrl_wr;
	logic            ack_wr;
	vrc6_pkg::byte_t latch;
	vrc6_pkg::byte_t count;
	logic            irq_m;     // 1 = cycle mode
	logic            irq_e;
	logic            irq_a;
	logic            timeout;
	logic [6:0]      prescale;
	logic [1:0]      line;      // Position in 113/113/112 rotation
	logic            irq_clk;
	logic            tick;

	assign page_wr  = ce & cpu_we & (reg_addr[15:12] == vrc6_pkg::PG_IRQ);
	assign latch_wr = page_wr & (reg_addr[1:0] == 2'd0);
	assign ctrl_wr  = page_wr & (reg_addr[1:0] == 2'd1);
	assign ack_wr   = page_wr & (reg_addr[1:0] == 2'd2);

	assign irq_clk = irq_m | (prescale == 7'd0);
	assign tick    = ce & irq_e & irq_clk;

	always_ff @(posedge clk) begin
		if (latch_wr) begin
			latch <= cpu_din;
		end
	end

	// Prescaler and counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count    <= '0;
			prescale <= '0;
			line     <= '0;
		end else if (ctrl_wr && cpu_din[1]) begin
			count    <= latch;
			prescale <= vrc6_pkg::PRESCALE_LONG;
			line     <= '0;
		end else if (ce && irq_e) begin
			if (prescale != 7'd0) begin
				prescale <= prescale - 7'd1;
			end else begin
				// Reload for the next line, short one third in rotation
				prescale <= (line == 2'd1) ? vrc6_pkg::PRESCALE_SHORT : vrc6_pkg::PRESCALE_LONG;
				line     <= line[1] ? 2'd0 : line + 2'd1;
			end
			if (irq_clk) begin
				count <= (count == 8'hFF) ? latch : count + 8'd1;
			end
		end
	end

	// Control bits and timeout flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_m   <= 1'b0;
			irq_e   <= 1'b0;
			irq_a   <= 1'b0;
			timeout <= 1'b0;
		end else if (ctrl_wr) begin
			{irq_m, irq_e, irq_a} <= cpu_din[2:0];
			timeout               <= 1'b0;
		end else if (ack_wr) begin
			irq_e   <= irq_a;   // Restore enable saved by A
			timeout <= 1'b0;
		end else if (tick && count == 8'hFF) begin
			timeout <= 1'b1;
		end
	end

	assign irq = timeout & irq_e;

endmodule

// ==== hw/vrc6_addr_map.sv ====
// VRC6 PRG, CHR and nametable mapping

`timescale 1ns/1ps

module vrc6_addr_map (
	input  vrc6_pkg::cpu_addr_t cpu_addr,
	input  vrc6_pkg::ppu_addr_t ppu_addr,
	input  logic [4:0]          prg16_bank,
	input  vrc6_pkg::prg_bank_t prg8_bank,
	input  vrc6_pkg::chr_bank_t chr_banks [8],
	input  vrc6_pkg::mirror_e   mirror,
	output logic [18:0]         prg_rom_addr,
	output logic                prg_ram_sel,
	output logic [17:0]         chr_rom_addr,
	output logic                ciram_ce,
	output logic                ciram_a10
);

	vrc6_pkg::prg_bank_t prg_page;
	vrc6_pkg::chr_bank_t chr_page;

	always_comb begin
		case (cpu_addr[15:13])
			3'b100,
			3'b101:  prg_page = {prg16_bank, cpu_addr[13]};   // 8000-BFFF
			3'b110:  prg_page = prg8_bank;                    // C000-DFFF
			3'b111:  prg_page = vrc6_pkg::LAST_PRG_PAGE;      // E000-FFFF
			default: prg_page = '0;
		endcase
	end

	assign prg_rom_addr = {prg_page, cpu_addr[vrc6_pkg::PRG_OFS_W-1:0]};
	assign prg_ram_sel  = (cpu_addr[15:13] == 3'b011);   // 6000-7FFF work RAM

	assign chr_page     = chr_banks[ppu_addr[12:10]];
	assign chr_rom_addr = {chr_page, ppu_addr[vrc6_pkg::CHR_OFS_W-1:0]};

	assign ciram_ce = ppu_addr[13];

	always_comb begin
		case (mirror)
			vrc6_pkg::MIR_VERT:   ciram_a10 = ppu_addr[10];
			vrc6_pkg::MIR_HORZ:   ciram_a10 = ppu_addr[11];
			vrc6_pkg::MIR_ONE_LO: ciram_a10 = 1'b0;
			default:              ciram_a10 = 1'b1;
		endcase
	end

endmodule

// ==== hw/vrc6_bank_regs.sv ====
// VRC6 bank and mirroring registers

`timescale 1ns/1ps

module vrc6_bank_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,
	input  logic                cpu_we,
	input  vrc6_pkg::cpu_addr_t reg_addr,
	input  vrc6_pkg::byte_t     cpu_din,
	output logic [4:0]          prg16_bank,
	output vrc6_pkg::prg_bank_t prg8_bank,
	output vrc6_pkg::chr_bank_t chr_banks [8],
	output vrc6_pkg::mirror_e   mirror
);

	vrc6_pkg::reg_page_e page;
	logic                wr;
	logic [2:0]          chr_idx;

	assign page = vrc6_pkg::reg_page_e'(reg_addr[15:12]);
	assign wr   = ce & cpu_we;

	// D000-D003 select banks 0-3, E000-E003 banks 4-7
	assign chr_idx = {page == vrc6_pkg::PG_CHR_HI, reg_addr[1:0]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prg16_bank <= '0;
			prg8_bank  <= '0;
			mirror     <= vrc6_pkg::MIR_VERT;
			for (int i = 0; i < 8; i++) begin
				chr_banks[i] <= '0;
			end
		end else if (wr) begin
			case (page)
				vrc6_pkg::PG_PRG16: begin
					prg16_bank <= cpu_din[4:0];   // 16 KiB window at 8000
				end
				vrc6_pkg::PG_PRG8: begin
					prg8_bank <= cpu_din[5:0];    // 8 KiB window at C000
				end
				vrc6_pkg::PG_SAW: begin
					// Only B003 lives here, the rest is the sawtooth
					if (reg_addr[1:0] == 2'd3) begin
						mirror <= vrc6_pkg::mirror_e'(cpu_din[3:2]);
					end
				end
				vrc6_pkg::PG_CHR_LO,
				vrc6_pkg::PG_CHR_HI: begin
					chr_banks[chr_idx] <= cpu_din;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/vrc6_pkg.sv ====
// VRC6 mapper shared types and constants

package vrc6_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  prg_bank_t;   // 8 KiB PRG page
	typedef logic [7:0]  chr_bank_t;   // 1 KiB CHR page
	typedef logic [5:0]  level_t;      // Summed audio, 0..61

	localparam int PRG_OFS_W = 13;
	localparam int CHR_OFS_W = 10;

	typedef enum logic [1:0] {
		MIR_VERT   = 2'd0,
		MIR_HORZ   = 2'd1,
		MIR_ONE_LO = 2'd2,
		MIR_ONE_HI = 2'd3
	} mirror_e;

	// Write pages, CPU address bits 15:12
	typedef enum logic [3:0] {
		PG_PRG16  = 4'h8,
		PG_PULSE1 = 4'h9,
		PG_PULSE2 = 4'hA,
		PG_SAW    = 4'hB,
		PG_PRG8   = 4'hC,
		PG_CHR_LO = 4'hD,
		PG_CHR_HI = 4'hE,
		PG_IRQ    = 4'hF
	} reg_page_e;

	localparam logic [6:0] PRESCALE_LONG  = 7'd113;
	localparam logic [6:0] PRESCALE_SHORT = 7'd112;

	localparam prg_bank_t LAST_PRG_PAGE = '1;   // Fixed page at E000

endpackage
